// File: rtl/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// raster, clk2 is the pixel clock
`define GAME_H_VISIBLE 256
`define GAME_H_FRONT 7          // pixels before hsync
`define GAME_H_SYNC 23
`define GAME_H_TOTAL 309
`define GAME_V_VISIBLE 240
`define GAME_V_FRONT 14         // lines before vsync
`define GAME_V_SYNC 3
`define GAME_V_TOTAL 262

// playfield objects
`define GAME_BRICKS_H 16
`define GAME_BRICKS_V 8
`define GAME_BALL_SIZE 6        // square ball
`define GAME_PADDLE_WIDTH 31
`define GAME_BALL_RESET_X 128
`define GAME_BALL_RESET_Y 180
`define GAME_MISS_Y 232         // first line of the bottom border row
`define GAME_LIVES_INIT 3

// apb byte offsets
`define GAME_REG_PADDLE 8'h00
`define GAME_REG_STATS 8'h04
`define GAME_REG_BALL 8'h08
`define GAME_REG_SERVE 8'h0C
`define GAME_REG_BRICKS 8'h10

`endif

// File: rtl/game_pkg.sv
package game_pkg;

  // beam state, fanned out to every drawing block
  typedef struct packed {
    logic [8:0] hpos;
    logic [8:0] vpos;
    logic       display_on;
    logic       hsync;
    logic       vsync;
    logic       frame_start;  // one cycle, line after vsync
    logic       frame_end;    // one cycle, first vsync line
  } beam_t;

  typedef struct packed {
    logic [8:0] x;
    logic [8:0] y;
    logic       dir_x;        // 1 right
    logic       dir_y;        // 1 down
    logic       speed;        // 1 = 2 px/frame on x
  } ball_t;

  // serve request from the host
  typedef struct packed {
    logic  valid;
    ball_t ball;
  } serve_t;

  typedef struct packed {
    logic [3:0] score1;       // bcd tens
    logic [3:0] score0;       // bcd units
    logic [3:0] lives;
  } stats_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

// File: rtl/video_timing.sv
`timescale 1ns/100ps
`include "game_cfg.svh"

module video_timing (
  input  logic            clk2,
  input  logic            reset,
  output game_pkg::beam_t beam
);

  localparam int hs_start = `GAME_H_VISIBLE + `GAME_H_FRONT;
  localparam int hs_end   = hs_start + `GAME_H_SYNC;
  localparam int vs_start = `GAME_V_VISIBLE + `GAME_V_FRONT;
  localparam int vs_end   = vs_start + `GAME_V_SYNC;

  logic [8:0] hcount;   // pixel in line
  logic [8:0] vcount;   // line in frame
  logic       line_end;

  assign line_end = (hcount == 9'(`GAME_H_TOTAL - 1));

  always_ff @(posedge clk2 or posedge reset) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (line_end) begin
      hcount <= '0;
      if (vcount == 9'(`GAME_V_TOTAL - 1)) begin
        vcount <= '0;   // wrap to top
      end else begin
        vcount <= vcount + 9'd1;
      end
    end else begin
      hcount <= hcount + 9'd1;
    end
  end

  // syncs and pulses straight from the counters
  always_comb begin
    beam.hpos        = hcount;
    beam.vpos        = vcount;
    beam.display_on  = (hcount < 9'(`GAME_H_VISIBLE)) && (vcount < 9'(`GAME_V_VISIBLE));
    beam.hsync       = (hcount >= 9'(hs_start)) && (hcount < 9'(hs_end));
    beam.vsync       = (vcount >= 9'(vs_start)) && (vcount < 9'(vs_end));
    beam.frame_end   = (vcount == 9'(vs_start)) && (hcount == 9'd0);
    beam.frame_start = (vcount == 9'(vs_end)) && (hcount == 9'd0);
  end

endmodule

// File: rtl/brick_field.sv
`timescale 1ns/100ps
`include "game_cfg.svh"

module brick_field (
  input  logic            clk2,
  input  logic            reset,
  input  game_pkg::beam_t beam,
  input  logic            brick_hit,
  output logic            brick_present,
  output logic            brick_gfx,
  output logic [7:0]      bricks_left
);

  localparam int num_bricks = `GAME_BRICKS_H * `GAME_BRICKS_V;

  logic [num_bricks-1:0] bricks;   // 1 = brick still standing
  logic [6:0]            brick_index;
  logic [5:0]            hcell;
  logic                  lr_border;
  logic                  in_band;

  assign hcell     = beam.hpos[8:3];
  assign lr_border = (hcell == 6'd0) || (hcell == 6'd31);   // side walls
  assign in_band   = (beam.vpos[8:6] == 3'd1) && !lr_border; // rows 8..15

  // brick index latched mid-cell, {row, column}
  always_ff @(posedge clk2) begin
    if (in_band && beam.hpos[3:0] == 4'd8) begin
      brick_index <= {beam.vpos[5:3], beam.hpos[7:4]};
    end
  end

  // brick bit fetched one pixel after the index
  always_ff @(posedge clk2 or posedge reset) begin
    if (reset) begin
      brick_present <= 1'b0;
    end else if (brick_hit) begin
      brick_present <= 1'b0;   // rest of this cell is gone on this line
    end else if (in_band) begin
      if (beam.hpos[3:0] == 4'd9) begin
        brick_present <= bricks[brick_index];
      end
    end else begin
      brick_present <= 1'b0;
    end
  end

  always_ff @(posedge clk2 or posedge reset) begin
    if (reset) begin
      bricks      <= '1;                // full wall
      bricks_left <= 8'(num_bricks);
    end else if (brick_hit) begin
      bricks[brick_index] <= 1'b0;
      bricks_left         <= bricks_left - 8'd1;
    end
  end

  // mortar: top line of each row and pixels 8..9 of each cell
  assign brick_gfx = lr_border ||
                     (brick_present && beam.vpos[2:0] != 3'd0 && beam.hpos[3:1] != 3'd4);

  // ball engine only reports hits on a live brick
  a_hit_on_brick: assert property (
    @(posedge clk2) disable iff (reset)
    brick_hit |-> brick_present
  );

endmodule

// File: rtl/ball_engine.sv
`timescale 1ns/100ps
`include "game_cfg.svh"

module ball_engine (
  input  logic             clk2,
  input  logic             reset,
  input  game_pkg::beam_t  beam,
  input  logic             main_gfx,
  input  logic             brick_present,
  input  logic [8:0]       paddle_pos,
  input  game_pkg::serve_t serve,
  input  logic             lives_zero,
  output game_pkg::ball_t  ball,
  output logic             ball_gfx,
  output logic             paddle_gfx,
  output logic             brick_hit,
  output logic             score_inc,
  output logic             life_lost
);

  // home position, heading down-right slowly
  localparam game_pkg::ball_t ball_home = '{
    x: 9'(`GAME_BALL_RESET_X), y: 9'(`GAME_BALL_RESET_Y),
    dir_x: 1'b1, dir_y: 1'b1, speed: 1'b0
  };

  logic [8:0]        ball_rel_x;
  logic [8:0]        ball_rel_y;
  logic [8:0]        paddle_rel_x;
  logic signed [8:0] ball_paddle_dx;
  logic [8:0]        step_x;
  logic              pixel_collide;
  logic [3:0]        collide_bits;   // quadrants: 0 tl, 1 tr, 2 bl, 3 br
  logic              collide_paddle;
  logic              serve_pend;
  game_pkg::ball_t   serve_ball;

  assign ball_rel_x   = beam.hpos - ball.x;
  assign ball_rel_y   = beam.vpos - ball.y;
  assign paddle_rel_x = beam.hpos - paddle_pos;   // wraps, so one compare
  assign ball_gfx     = (ball_rel_x < 9'(`GAME_BALL_SIZE)) && (ball_rel_y < 9'(`GAME_BALL_SIZE));
  assign paddle_gfx   = (beam.vpos[8:3] == 6'd28) && (paddle_rel_x < 9'(`GAME_PADDLE_WIDTH));

  // the bottom border row lets the ball through so it can be missed
  assign pixel_collide = main_gfx && ball_gfx && beam.display_on &&
                         (beam.vpos < 9'(`GAME_MISS_Y));
  assign brick_hit      = pixel_collide && brick_present;
  assign ball_paddle_dx = ball.x - paddle_pos + 9'd8;   // offset from paddle left end
  assign step_x         = ball.speed ? 9'd2 : 9'd1;

  always_ff @(posedge clk2) begin
    if (serve.valid) begin
      serve_ball <= serve.ball;
    end
  end

  always_ff @(posedge clk2 or posedge reset) begin
    if (reset) begin
      ball           <= ball_home;
      collide_bits   <= '0;
      collide_paddle <= 1'b0;
      serve_pend     <= 1'b0;
      score_inc      <= 1'b0;
      life_lost      <= 1'b0;
    end else begin
      score_inc <= brick_hit;
      life_lost <= 1'b0;
      if (beam.frame_end) begin
        if (collide_paddle) begin
          ball.dir_y <= 1'b0;                               // up off the paddle
          ball.dir_x <= (ball_paddle_dx >= 9'sd20);         // by paddle side
          ball.speed <= (collide_bits != 4'b1100);          // edge hit speeds up
        end else begin
          casez (collide_bits)
            4'b01?1, 4'b1101: ball.dir_x <= 1'b1;   // left edge or corner
            4'b101?, 4'b1110: ball.dir_x <= 1'b0;   // right edge or corner
            default: ;
          endcase
          casez (collide_bits)
            4'b1011, 4'b0111, 4'b001?, 4'b0001: ball.dir_y <= 1'b1;   // hit from above
            4'b0100, 4'b1?00, 4'b1101, 4'b1110: ball.dir_y <= 1'b0;   // hit from below
            default: ;
          endcase
        end
        collide_bits   <= '0;   // fresh for next frame
        collide_paddle <= 1'b0;
      end else if (pixel_collide) begin
        collide_bits[{ball_rel_y[2], ball_rel_x[2]}] <= 1'b1;
        if (paddle_gfx) begin
          collide_paddle <= 1'b1;
        end
      end
      if (beam.frame_start && !lives_zero) begin   // frozen with no lives
        if (serve_pend) begin
          ball       <= serve_ball;
          serve_pend <= 1'b0;
        end else if (ball.y >= 9'(`GAME_MISS_Y)) begin
          ball      <= ball_home;   // missed, back home
          life_lost <= 1'b1;
        end else begin
          ball.x <= ball.dir_x ? ball.x + step_x : ball.x - step_x;
          ball.y <= ball.dir_y ? ball.y + 9'd1 : ball.y - 9'd1;
        end
      end
      if (serve.valid) begin
        serve_pend <= 1'b1;   // new request outlives a same-cycle apply
      end
    end
  end

  // each hit scores once and knocks the brick out of the scan
  a_hit_scores: assert property (
    @(posedge clk2) disable iff (reset)
    brick_hit |=> !brick_present
  );

endmodule

// File: rtl/score_keeper.sv
`timescale 1ns/100ps
`include "game_cfg.svh"

module score_keeper (
  input  logic             clk2,
  input  logic             reset,
  input  game_pkg::beam_t  beam,
  input  logic             score_inc,
  input  logic             life_lost,
  output game_pkg::stats_t stats,
  output logic             lives_zero,
  output logic             score_gfx
);

  // 5x5 glyphs, top row in the msbs, left column first
  localparam logic [24:0] glyphs [10] = '{
    25'b11111_10001_10001_10001_11111,
    25'b01100_00100_00100_00100_01110,
    25'b11111_00001_11111_10000_11111,
    25'b11111_00001_11111_00001_11111,
    25'b10001_10001_11111_00001_00001,
    25'b11111_10000_11111_00001_11111,
    25'b11111_10000_11111_10001_11111,
    25'b11111_00001_00001_00001_00001,
    25'b11111_10001_11111_10001_11111,
    25'b11111_10001_11111_00001_11111
  };

  logic [3:0]  digit;
  logic [2:0]  xofs;
  logic [2:0]  yofs;
  logic [24:0] glyph;
  logic [4:0]  bit_sel;

  always_ff @(posedge clk2 or posedge reset) begin
    if (reset) begin
      stats <= '{score1: 4'd0, score0: 4'd0, lives: 4'(`GAME_LIVES_INIT)};
    end else begin
      if (score_inc) begin
        if (stats.score0 == 4'd9) begin
          stats.score0 <= 4'd0;   // carry into tens, 99 wraps to 00
          stats.score1 <= (stats.score1 == 4'd9) ? 4'd0 : stats.score1 + 4'd1;
        end else begin
          stats.score0 <= stats.score0 + 4'd1;
        end
      end
      if (life_lost && !lives_zero) begin
        stats.lives <= stats.lives - 4'd1;
      end
    end
  end

  assign lives_zero = (stats.lives == 4'd0);

  // 32-pixel digit slots across the top
  always_comb begin
    case (beam.hpos[7:5])
      3'd1:    digit = stats.score1;
      3'd2:    digit = stats.score0;
      3'd6:    digit = stats.lives;
      default: digit = 4'd15;   // blank
    endcase
  end

  assign xofs    = beam.hpos[4:2];   // 4x4 pixel dots
  assign yofs    = beam.vpos[4:2];
  assign glyph   = (digit < 4'd10) ? glyphs[digit] : '0;
  assign bit_sel = 5'd24 - 5'(yofs) * 5'd5 - 5'(xofs);

  // char rows 0..2 only
  assign score_gfx = !beam.hpos[8] && (beam.vpos < 9'd24) &&
                     (xofs < 3'd5) && (yofs < 3'd5) && glyph[bit_sel];

endmodule

// File: rtl/apb_paddle_regs.sv
`timescale 1ns/100ps
`include "game_cfg.svh"

module apb_paddle_regs (
  input  logic               clk2,
  input  logic               reset,
  input  game_pkg::apb_req_t apb_req,
  output game_pkg::apb_rsp_t apb_rsp,
  input  game_pkg::stats_t   stats,
  input  game_pkg::ball_t    ball,
  input  logic [7:0]         bricks_left,
  output logic [8:0]         paddle_pos,
  output game_pkg::serve_t   serve
);

  logic            access;     // second apb cycle
  logic            addr_ok;
  logic            ro_addr;
  logic [31:0]     rdata;
  logic            serve_valid;
  game_pkg::ball_t serve_ball;

  assign access = apb_req.psel && apb_req.penable;

  always_comb begin
    addr_ok = 1'b1;
    ro_addr = 1'b0;
    rdata   = '0;
    case (apb_req.paddr)
      `GAME_REG_PADDLE: rdata = {23'd0, paddle_pos};
      `GAME_REG_STATS: begin
        rdata   = {20'd0, stats.lives, stats.score1, stats.score0};
        ro_addr = 1'b1;
      end
      `GAME_REG_BALL: begin
        rdata   = {1'b0, ball.speed, ball.dir_y, ball.dir_x, 3'd0, ball.y, 7'd0, ball.x};
        ro_addr = 1'b1;
      end
      `GAME_REG_SERVE: ;   // write only, reads zero
      `GAME_REG_BRICKS: begin
        rdata   = {24'd0, bricks_left};
        ro_addr = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  // zero wait, error only in the access cycle
  assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : 32'd0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (!addr_ok || (apb_req.pwrite && ro_addr));

  always_ff @(posedge clk2 or posedge reset) begin
    if (reset) begin
      paddle_pos  <= '0;
      serve_valid <= 1'b0;
    end else begin
      serve_valid <= access && apb_req.pwrite && apb_req.paddr == `GAME_REG_SERVE;
      if (access && apb_req.pwrite && apb_req.paddr == `GAME_REG_PADDLE) begin
        paddle_pos <= apb_req.pwdata[8:0];
      end
    end
  end

  // serve word unpacked, same layout as the ball word
  always_ff @(posedge clk2) begin
    if (access && apb_req.pwrite && apb_req.paddr == `GAME_REG_SERVE) begin
      serve_ball <= '{x: apb_req.pwdata[8:0], y: apb_req.pwdata[24:16],
                      dir_x: apb_req.pwdata[28], dir_y: apb_req.pwdata[29],
                      speed: apb_req.pwdata[30]};
    end
  end

  assign serve = '{valid: serve_valid, ball: serve_ball};

  a_penable_psel: assert property (
    @(posedge clk2) disable iff (reset)
    apb_req.penable |-> apb_req.psel
  );

endmodule

// File: rtl/ball_paddle_top.sv
`timescale 1ns/100ps

module ball_paddle_top (
  input  logic               clk2,
  input  logic               reset,
  input  game_pkg::apb_req_t apb_req,
  output game_pkg::apb_rsp_t apb_rsp,
  output logic               hsync,
  output logic               vsync,
  output logic [1:0]         out
);

  game_pkg::beam_t  beam;
  game_pkg::ball_t  ball;
  game_pkg::serve_t serve;
  game_pkg::stats_t stats;
  logic             brick_present;
  logic             brick_gfx;
  logic             ball_gfx;
  logic             paddle_gfx;
  logic             score_gfx;
  logic             main_gfx;    // bricks, borders, scoreboard
  logic             brick_hit;
  logic             score_inc;
  logic             life_lost;
  logic             lives_zero;
  logic [7:0]       bricks_left;
  logic [8:0]       paddle_pos;
  logic             lr_border;
  logic             r;
  logic             g;
  logic             b;

  video_timing u_timing (.clk2, .reset, .beam);

  brick_field u_bricks (.clk2, .reset, .beam, .brick_hit, .brick_present, .brick_gfx,
                        .bricks_left);

  ball_engine u_ball (.clk2, .reset, .beam, .main_gfx, .brick_present, .paddle_pos,
                      .serve, .lives_zero, .ball, .ball_gfx, .paddle_gfx, .brick_hit,
                      .score_inc, .life_lost);

  score_keeper u_score (.clk2, .reset, .beam, .score_inc, .life_lost, .stats,
                        .lives_zero, .score_gfx);

  apb_paddle_regs u_regs (.clk2, .reset, .apb_req, .apb_rsp, .stats, .ball, .bricks_left,
                          .paddle_pos, .serve);

  assign lr_border = (beam.hpos[8:3] == 6'd0) || (beam.hpos[8:3] == 6'd31);

  // playfield by 8-line char row
  always_comb begin
    case (beam.vpos[8:3])
      6'd0, 6'd1, 6'd2: main_gfx = score_gfx;
      6'd3:             main_gfx = 1'b0;        // gap under the score
      6'd4:             main_gfx = 1'b1;        // top border
      6'd8, 6'd9, 6'd10, 6'd11,
      6'd12, 6'd13, 6'd14, 6'd15: main_gfx = brick_gfx;
      6'd28:            main_gfx = paddle_gfx | lr_border;
      6'd29:            main_gfx = beam.hpos[0] ^ beam.vpos[0];   // checkered floor
      default:          main_gfx = lr_border;
    endcase
  end

  assign r = beam.display_on && (ball_gfx | paddle_gfx);
  assign g = beam.display_on && (main_gfx | ball_gfx);
  assign b = beam.display_on && (ball_gfx | brick_present);

  assign hsync = beam.hsync;
  assign vsync = beam.vsync;
  assign out   = (beam.hsync || beam.vsync) ? 2'd0 : 2'd1 + 2'(g) + 2'(r | b);

endmodule

// File: bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  int error_count  = 0;
  int test_count   = 0;
  int failed_tests = 0;

  // single compare used by every check
  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  // one line per finished test
  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count != errs_before) begin
      failed_tests++;
      $display("FAIL  %s", name);
    end else begin
      $display("ok    %s", name);
    end
  endtask

  task automatic print_counts;
    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
  endtask

`endif

// File: bench/tb_ball_paddle.sv
`timescale 1ns/100ps
`include "game_cfg.svh"

module tb_ball_paddle;

  localparam logic [31:0] pos_mask = 32'h01ff01ff;   // x and y fields only

  logic               clk2;
  logic               reset;
  game_pkg::apb_req_t apb_req;
  game_pkg::apb_rsp_t apb_rsp;
  logic               hsync;
  logic               vsync;
  logic [1:0]         out;

  // test table, one apb access per row
  string       t_name [64];
  int          t_frames [64];   // frames to wait first
  logic [7:0]  t_addr [64];
  logic        t_write [64];
  logic [31:0] t_wdata [64];
  logic [31:0] t_expect [64];
  logic [31:0] t_mask [64];     // compared read bits
  logic        t_err [64];      // expected pslverr
  int          n_entries;
  logic        table_ready;

  integer      seed;
  int          frame_count;
  logic        vsync_q;
  int          blank_errors = 0;
  logic        hsync_q;
  int          hsync_len;       // edges since the last hsync rise
  int          line_errors = 0;

  `include "tb_checks.svh"

  ball_paddle_top i_dut (.clk2, .reset, .apb_req, .apb_rsp, .hsync, .vsync, .out);

  initial begin
    clk2 = 1'b0;
    forever #20 clk2 = ~clk2;   // 25 MHz pixel clock
  end

  // frame count steps on the vsync fall, the same edge as frame_start
  always @(posedge clk2 or posedge reset) begin
    if (reset) begin
      frame_count <= 0;
      vsync_q     <= 1'b0;
    end else begin
      vsync_q <= vsync;
      if (vsync_q && !vsync) begin
        frame_count <= frame_count + 1;
      end
    end
  end

  // pixel output dark in either sync, lit outside it
  always @(posedge clk2) begin
    if (!reset && (hsync || vsync) && out !== 2'd0) begin
      if (blank_errors == 0) begin
        $display("pixel output not blanked during sync at %0t", $time);
      end
      blank_errors++;
    end else if (!reset && !hsync && !vsync && out === 2'd0) begin
      if (blank_errors == 0) begin
        $display("pixel output dark outside sync at %0t", $time);
      end
      blank_errors++;
    end
  end

  // every line is h_total pixels, hsync rise to rise
  always @(posedge clk2 or posedge reset) begin
    if (reset) begin
      hsync_q   <= 1'b0;
      hsync_len <= 0;
    end else begin
      hsync_q <= hsync;
      if (hsync_len != 0) begin
        hsync_len <= hsync_len + 1;
      end
      if (hsync && !hsync_q) begin
        hsync_len <= 1;   // first rise only starts the count
        if (hsync_len != 0 && hsync_len != `GAME_H_TOTAL) begin
          $display("hsync line length %0d pixels at %0t", hsync_len, $time);
          line_errors++;
        end
      end
    end
  end

  // ball register layout, x in 8..0, y in 24..16
  function automatic logic [31:0] pos_word(input int x, input int y);
    return {7'd0, 9'(y), 7'd0, 9'(x)};
  endfunction

  function automatic logic [31:0] serve_word(input int x, input int y, input logic dir_x,
                                             input logic dir_y, input logic speed);
    return pos_word(x, y) | {1'b0, speed, dir_y, dir_x, 28'd0};
  endfunction

  function automatic int total_frames;
    int sum;
    sum = 0;
    for (int i = 0; i < n_entries; i++) begin
      sum += t_frames[i];
    end
    return sum;
  endfunction

  task automatic add_entry(input string name, input int frames, input logic [7:0] addr,
                           input logic write, input logic [31:0] wdata,
                           input logic [31:0] expect_rd, input logic [31:0] mask,
                           input logic err);
    t_name[n_entries]   = name;
    t_frames[n_entries] = frames;
    t_addr[n_entries]   = addr;
    t_write[n_entries]  = write;
    t_wdata[n_entries]  = wdata;
    t_expect[n_entries] = expect_rd;
    t_mask[n_entries]   = mask;
    t_err[n_entries]    = err;
    n_entries++;
  endtask

  task automatic build_table;
    logic [31:0] paddle_word;
    logic [31:0] paddle_val;
    logic [31:0] lives_init;
    n_entries   = 0;
    paddle_word = $random(seed);
    paddle_val  = {23'd0, paddle_word[8:0]};
    lives_init  = 32'(`GAME_LIVES_INIT);
    // reset state, before the first frame_start
    add_entry("reset_stats", 0, `GAME_REG_STATS, 0, 0, lives_init << 8, 32'hfff, 0);
    add_entry("reset_ball", 0, `GAME_REG_BALL, 0, 0,
              pos_word(`GAME_BALL_RESET_X, `GAME_BALL_RESET_Y), pos_mask, 0);
    add_entry("reset_bricks", 0, `GAME_REG_BRICKS, 0, 0,
              32'(`GAME_BRICKS_H * `GAME_BRICKS_V), 32'hff, 0);
    add_entry("reset_paddle", 0, `GAME_REG_PADDLE, 0, 0, 0, 32'h1ff, 0);
    // register access and error responses
    add_entry("paddle_write", 0, `GAME_REG_PADDLE, 1, paddle_word, 0, 0, 0);
    add_entry("paddle_readback", 0, `GAME_REG_PADDLE, 0, 0, paddle_val, 32'h1ff, 0);
    add_entry("stats_write_err", 0, `GAME_REG_STATS, 1, 32'h999, 0, 0, 1);
    add_entry("unknown_read_err", 0, 8'h14, 0, 0, 0, 0, 1);
    add_entry("paddle_kept", 0, `GAME_REG_PADDLE, 0, 0, paddle_val, 32'h1ff, 0);
    // free flight, serve lands on the first frame, then one pixel per frame
    add_entry("serve_free", 0, `GAME_REG_SERVE, 1, serve_word(60, 150, 1, 1, 0), 0, 0, 0);
    add_entry("free_served", 1, `GAME_REG_BALL, 0, 0, pos_word(60, 150), pos_mask, 0);
    add_entry("free_5", 5, `GAME_REG_BALL, 0, 0, pos_word(65, 155), pos_mask, 0);
    // up and left, reaches line 127 of brick row 7 on frame 8
    add_entry("serve_brick", 0, `GAME_REG_SERVE, 1, serve_word(82, 134, 0, 0, 0), 0, 0, 0);
    add_entry("brick_score", 10, `GAME_REG_STATS, 0, 0, (lives_init << 8) | 32'h01,
              32'hfff, 0);
    add_entry("brick_count", 0, `GAME_REG_BRICKS, 0, 0,
              32'(`GAME_BRICKS_H * `GAME_BRICKS_V - 1), 32'hff, 0);
    add_entry("brick_bounce", 0, `GAME_REG_BALL, 0, 0, pos_word(73, 129), pos_mask, 0);
    add_entry("brick_bounce_later", 2, `GAME_REG_BALL, 0, 0, pos_word(71, 131), pos_mask, 0);
    // miss: y hits 232 on frame 5, home on frame 6, ten moves after that
    add_entry("paddle_200", 0, `GAME_REG_PADDLE, 1, 32'd200, 0, 0, 0);
    add_entry("serve_miss", 0, `GAME_REG_SERVE, 1, serve_word(40, 228, 1, 1, 0), 0, 0, 0);
    add_entry("miss_stats", 16, `GAME_REG_STATS, 0, 0, ((lives_init - 1) << 8) | 32'h01,
              32'hfff, 0);
    add_entry("miss_ball", 0, `GAME_REG_BALL, 0, 0,
              pos_word(`GAME_BALL_RESET_X + 10, `GAME_BALL_RESET_Y + 10), pos_mask, 0);
  endtask

  // frame_count lags one edge, so the ball has already moved on return
  task automatic wait_frames(input int n);
    int target;
    target = frame_count + n;
    while (frame_count < target) begin
      @(posedge clk2);
    end
  endtask

  task automatic apb_transfer(input logic [7:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    @(posedge clk2);
    #2;
    apb_req.psel    = 1'b1;   // setup
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk2);
    #2;
    apb_req.penable = 1'b1;   // access
    waits = 0;
    @(negedge clk2);
    while (!apb_rsp.pready && waits < 16) begin
      @(negedge clk2);
      waits++;
    end
    if (!apb_rsp.pready) begin
      $display("apb transfer to 0x%02h never got pready", addr);
      error_count++;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk2);
    #2;
    apb_req = '0;
  endtask

  // watchdog sized from the table
  initial begin
    longint limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = 64'(total_frames() + 2) * `GAME_H_TOTAL * `GAME_V_TOTAL * 40;
    #(limit_ns);
    $display("watchdog expired after %0d ns, test table did not finish", limit_ns);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          errs_before;
    reset       = 1'b1;
    apb_req     = '0;
    table_ready = 1'b0;
    seed        = 32'he44ff95e;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk2);
    #2;
    reset = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      errs_before = error_count;
      wait_frames(t_frames[i]);
      apb_transfer(t_addr[i], t_write[i], t_wdata[i], rdata, err);
      if (t_mask[i] != 32'd0) begin   // writes and error reads carry no data
        compare_value(t_name[i], t_expect[i], rdata & t_mask[i]);
      end
      compare_value({t_name[i], " pslverr"}, 32'(t_err[i]), 32'(err));
      report_test(t_name[i], errs_before);
    end
    errs_before = error_count;
    compare_value("sync_blanking", 32'd0, 32'(blank_errors));   // whole run
    report_test("sync_blanking", errs_before);
    errs_before = error_count;
    compare_value("line_length", 32'd0, 32'(line_errors));
    report_test("line_length", errs_before);
    print_counts();
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
+incdir+bench
rtl/game_pkg.sv
rtl/video_timing.sv
rtl/brick_field.sv
rtl/ball_engine.sv
rtl/score_keeper.sv
rtl/apb_paddle_regs.sv
rtl/ball_paddle_top.sv
bench/tb_ball_paddle.sv
